/* hw/least_loaded_picker.sv */
`timescale 1ns/1ps

module least_loaded_picker import router_dim_pkg::*, select_if_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  select_req_t  req,
    input  load_t        loads [NUM_PORTS],
    input  select_cfg_t  cfg,
    output select_resp_t resp
);

    // compare key is one bit wider than a load
    localparam int KEY_W = LOAD_W + 1;

    // ports that pass mask, enable and cap
    port_mask_t eligible;

    // sort key per port
    logic [KEY_W-1:0] key [NUM_PORTS];

    // pairwise result, row i against every other port
    logic [NUM_PORTS-2:0] beats [NUM_PORTS];

    // one-hot minimum
    port_mask_t winner;

    // encoded winner
    port_idx_t win_idx;
    load_t     win_load;

    // any port left after masking
    logic found;

    // eligibility and keys
    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            eligible[i] = req.cand[i] & cfg.port_en[i] & (loads[i] <= cfg.load_cap);
            // top bit pushes ineligible ports above LOAD_MAX
            key[i] = {~eligible[i], loads[i]};
        end
    end

    assign found = |eligible;

    // triangular minimum finder
    // upper half compares against higher ports with <=,
    // lower half reuses the mirrored result inverted,
    // so a tie always goes to the lower index
    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_row
        for (genvar j = 0; j < NUM_PORTS - 1; j++) begin : g_col
            if (i > j) begin : g_lower
                assign beats[i][j] = ~beats[j][i-1];
            end else begin : g_upper
                assign beats[i][j] = (key[i] <= key[j+1]);
            end
        end
        // winner must beat every other port
        assign winner[i] = &beats[i];
    end

    // one-hot to binary by masked OR
    // the load is picked with the same mask
    always_comb begin
        win_idx = '0;
        win_load = '0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            win_idx = win_idx | ({PORT_IDX_W{winner[i]}} & port_idx_t'(i));
            win_load = win_load | ({LOAD_W{winner[i]}} & loads[i]);
        end
    end

    // output register, loaded every cycle
    // one request in flight, the next one accepted meanwhile
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            resp <= '0;
        end else begin
            resp.valid <= req.strobe;
            resp.found <= found;
            // still a winner when nothing is eligible
            // zeroed here
            resp.port <= found ? win_idx : '0;
            resp.load <= found ? win_load : '0;
        end
    end

endmodule

/* hw/port_select_top.sv */
`timescale 1ns/1ps

module port_select_top import router_dim_pkg::*, select_if_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  select_req_t  req,
    input  vc_busy_t     vc_busy [NUM_PORTS],
    input  cfg_wr_t      cfg_wr,
    output select_resp_t resp
);

    // per-port busy counts
    // combinational, same cycle as the strobe
    load_t loads [NUM_PORTS];

    // live configuration
    select_cfg_t cfg;

    // one counter per output port
    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_cnt
        vc_busy_counter i_cnt (
            .vc_busy (vc_busy[p]),
            .load    (loads[p])
        );
    end

    // enable mask and load cap
    select_cfg_regs i_cfg (
        .clk    (clk),
        .rst_n  (rst_n),
        .cfg_wr (cfg_wr),
        .cfg    (cfg)
    );

    // masking, minimum and output register
    // resp valid one cycle after req.strobe
    least_loaded_picker i_pick (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .loads (loads),
        .cfg   (cfg),
        .resp  (resp)
    );

endmodule

/* hw/router_dim_pkg.sv */
package router_dim_pkg;

    // candidate output ports seen by the selector
    localparam int NUM_PORTS = 4;

    // virtual channels per output port
    localparam int NUM_VCS = 7;

    // all channels of a port busy
    localparam int LOAD_MAX = NUM_VCS;

    // derived widths
    localparam int LOAD_W = $clog2(LOAD_MAX + 1);
    localparam int PORT_IDX_W = $clog2(NUM_PORTS);

    // one bit per port
    // also used for one-hot port choices
    typedef logic [NUM_PORTS-1:0] port_mask_t;

    // busy flag per virtual channel of one port
    typedef logic [NUM_VCS-1:0] vc_busy_t;

    // number of busy channels on one port
    typedef logic [LOAD_W-1:0] load_t;

    // binary port number
    typedef logic [PORT_IDX_W-1:0] port_idx_t;

endpackage

/* hw/select_cfg_regs.sv */
`timescale 1ns/1ps

module select_cfg_regs import router_dim_pkg::*, select_if_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  cfg_wr_t     cfg_wr,
    output select_cfg_t cfg
);

    // decoded write enables
    logic wr_port_en;
    logic wr_load_cap;

    // write data cut to the field widths
    port_mask_t wdata_mask;
    load_t      wdata_cap;

    // one address bit selects the register
    assign wr_port_en = cfg_wr.we & (cfg_wr.addr == CFG_ADDR_PORT_EN);
    assign wr_load_cap = cfg_wr.we & (cfg_wr.addr == CFG_ADDR_LOAD_CAP);

    // enable mask takes the full data word
    assign wdata_mask = cfg_wr.wdata[NUM_PORTS-1:0];

    // cap takes the low bits only
    assign wdata_cap = cfg_wr.wdata[LOAD_W-1:0];

    // port enable mask
    // all ports usable out of reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cfg.port_en <= '1;
        end else if (wr_port_en) begin
            cfg.port_en <= wdata_mask;
        end
    end

    // load cap
    // no cap out of reset, every load passes
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cfg.load_cap <= load_t'(LOAD_MAX);
        end else if (wr_load_cap) begin
            cfg.load_cap <= wdata_cap;
        end
    end

    // new values show on cfg the cycle after the write,
    // so a request in the write cycle still sees the old ones

endmodule

/* hw/select_if_pkg.sv */
package select_if_pkg;

    import router_dim_pkg::*;

    // config write data width
    localparam int CFG_WDATA_W = 4;

    // config register map
    localparam logic CFG_ADDR_PORT_EN = 1'b0;
    localparam logic CFG_ADDR_LOAD_CAP = 1'b1;

    // request from the route computation
    // strobe is a single-cycle pulse
    typedef struct packed {
        logic       strobe;
        port_mask_t cand;
    } select_req_t;

    // response, one cycle after the strobe
    // port and load are zero when found is low
    typedef struct packed {
        logic      valid;
        logic      found;
        port_idx_t port;
        load_t     load;
    } select_resp_t;

    // live configuration
    typedef struct packed {
        port_mask_t port_en;
        load_t      load_cap;
    } select_cfg_t;

    // config write port
    typedef struct packed {
        logic                   we;
        logic                   addr;
        logic [CFG_WDATA_W-1:0] wdata;
    } cfg_wr_t;

endpackage

/* hw/vc_busy_counter.sv */
`timescale 1ns/1ps

module vc_busy_counter import router_dim_pkg::*; (
    input  vc_busy_t vc_busy,
    output load_t    load
);

    // lower group of four channels
    logic [3:0] grp_lo;
    // upper group of three channels
    logic [2:0] grp_hi;

    // partial counts of each group
    logic [2:0] cnt_lo;
    logic [1:0] cnt_hi;

    // weight-two carries
    logic carry_a;
    logic carry_b;
    logic carry_c;

    // weight-one sum bit
    logic sum_s;

    assign {grp_hi, grp_lo} = vc_busy;

    // small adders for the two groups
    // zero extended so no bit is lost
    assign cnt_lo = 3'(grp_lo[0]) + 3'(grp_lo[1]) + 3'(grp_lo[2]) + 3'(grp_lo[3]);
    assign cnt_hi = 2'(grp_hi[0]) + 2'(grp_hi[1]) + 2'(grp_hi[2]);

    // parity of the whole bitmap
    assign sum_s = cnt_lo[0] ^ cnt_hi[0];

    // lower group holds at least one pair
    assign carry_a = (cnt_lo > 3'd1);

    // upper group holds at least one pair
    assign carry_b = (cnt_hi > 2'd1);

    // second pair in the lower group (count of four),
    // or two odd leftovers that make one more pair
    assign carry_c = (cnt_lo == 3'd4) | (cnt_lo[0] & cnt_hi[0]);

    // carry-sum stage done
    // bit 0 is the parity
    assign load[0] = sum_s;

    // second stage adds the three carries
    // at most three, fits the upper two bits
    assign load[2:1] = 2'(carry_a) + 2'(carry_b) + 2'(carry_c);

endmodule

/* list.f */
+incdir+testbench
hw/router_dim_pkg.sv
hw/select_if_pkg.sv
hw/vc_busy_counter.sv
hw/select_cfg_regs.sv
hw/least_loaded_picker.sv
hw/port_select_top.sv
testbench/tb_port_select.sv

/* testbench/tb_port_select_tests.svh */
`ifndef TB_PORT_SELECT_TESTS_SVH
`define TB_PORT_SELECT_TESTS_SVH

// low l channels busy on each port
function automatic busy_arr_t busy_from_loads(input int l0, input int l1,
                                              input int l2, input int l3);
    busy_arr_t b;
    b[0] = vc_busy_t'((1 << l0) - 1);
    b[1] = vc_busy_t'((1 << l1) - 1);
    b[2] = vc_busy_t'((1 << l2) - 1);
    b[3] = vc_busy_t'((1 << l3) - 1);
    return b;
endfunction

// sets up a config write without advancing time
task automatic stage_cfg_write(input logic addr, input logic [CFG_WDATA_W-1:0] wdata);
    cfg_wr.we = 1'b1;
    cfg_wr.addr = addr;
    cfg_wr.wdata = wdata;
    if (addr == CFG_ADDR_PORT_EN) begin
        model_en = wdata[NUM_PORTS-1:0];
    end else begin
        model_cap = wdata[LOAD_W-1:0];
    end
endtask

task automatic write_cfg(input logic addr, input logic [CFG_WDATA_W-1:0] wdata);
    stage_cfg_write(addr, wdata);
    @(negedge clk);
    cfg_wr.we = 1'b0;
endtask

task automatic reset_state();
    check_flag("resp.valid", 1'b0, resp.valid);
    check_flag("resp.found", 1'b0, resp.found);
    check_port("resp.port", '0, resp.port);
    check_load("resp.load", '0, resp.load);
    // idle cycles without a strobe
    for (int i = 0; i < 5; i++) begin
        @(negedge clk);
        check_flag("resp.valid", 1'b0, resp.valid);
    end
    finish_test("reset_state");
endtask

task automatic counter_values();
    // index k holds a bitmap with k busy channels
    vc_busy_t patterns [8] = '{7'b0000000, 7'b0001000, 7'b1000001, 7'b0010101,
                               7'b1010101, 7'b1101101, 7'b1111011, 7'b1111111};
    busy_arr_t busy;
    select_resp_t exp;
    for (int p = 0; p < NUM_PORTS; p++) begin
        for (int k = 0; k <= LOAD_MAX; k++) begin
            // only port p is a candidate
            // the others get the complement
            for (int q = 0; q < NUM_PORTS; q++) begin
                busy[q] = ~patterns[k];
            end
            busy[p] = patterns[k];
            exp = '0;
            exp.valid = 1'b1;
            exp.found = 1'b1;
            exp.port = port_idx_t'(p);
            exp.load = load_t'(k);
            run_request(port_mask_t'(1 << p), busy, exp);
        end
    end
    finish_test("counter_values");
endtask

task automatic random_traffic();
    port_mask_t cand;
    busy_arr_t busy;
    for (int i = 0; i < 40; i++) begin
        random_inputs(cand, busy);
        check_request(cand, busy);
    end
    // no candidate at all
    check_request('0, busy);
    finish_test("random_traffic");
endtask

task automatic back_to_back();
    port_mask_t cand;
    busy_arr_t busy;
    select_resp_t exp_q [$];
    select_resp_t exp;
    for (int k = 0; k <= 6; k++) begin
        // response of the previous strobe
        if (k > 0) begin
            exp = exp_q.pop_front();
            check_flag("resp.valid", 1'b1, resp.valid);
            expect_resp(exp, resp);
        end
        if (k < 6) begin
            random_inputs(cand, busy);
            exp_q.push_back(model_select(cand, busy, model_en, model_cap));
            req.strobe = 1'b1;
            req.cand = cand;
            vc_busy = busy;
        end else begin
            req.strobe = 1'b0;
        end
        @(negedge clk);
    end
    // nothing after the last one
    check_flag("resp.valid", 1'b0, resp.valid);
    finish_test("back_to_back");
endtask

task automatic config_changes();
    busy_arr_t busy;
    select_resp_t exp;
    // ports 1 and 3 off while port 1 is least loaded
    write_cfg(CFG_ADDR_PORT_EN, 4'b0101);
    check_request(4'hf, busy_from_loads(5, 0, 2, 1));
    write_cfg(CFG_ADDR_PORT_EN, 4'hf);
    // cap 2 with every port above it
    write_cfg(CFG_ADDR_LOAD_CAP, 4'd2);
    check_request(4'hf, busy_from_loads(3, 4, 5, 7));
    // tie at the cap between ports 1 and 3
    check_request(4'hf, busy_from_loads(3, 2, 5, 2));
    // cap lifted again
    write_cfg(CFG_ADDR_LOAD_CAP, 4'(LOAD_MAX));
    check_request(4'hf, busy_from_loads(3, 4, 5, 7));
    // write cap 0 with a request in the same cycle
    busy = busy_from_loads(3, 4, 5, 7);
    exp = model_select(4'hf, busy, model_en, model_cap);
    stage_cfg_write(CFG_ADDR_LOAD_CAP, 4'd0);
    run_request(4'hf, busy, exp);
    // new cap in force so only the idle port passes
    check_request(4'hf, busy_from_loads(3, 4, 0, 7));
    write_cfg(CFG_ADDR_LOAD_CAP, 4'(LOAD_MAX));
    finish_test("config_changes");
endtask

`endif

/* testbench/tb_port_select.sv */
`timescale 1ns/1ps

module tb_port_select import router_dim_pkg::*, select_if_pkg::*; ();

    // busy bitmaps of all ports as one value
    typedef vc_busy_t busy_arr_t [NUM_PORTS];

    localparam logic [31:0] LFSR_SEED = 32'h5ea2_7674;
    localparam int RESP_TIMEOUT = 10;

    logic         clk = 1'b0;
    logic         rst_n;
    select_req_t  req;
    busy_arr_t    vc_busy;
    cfg_wr_t      cfg_wr;
    select_resp_t resp;

    // random source
    logic [31:0] lfsr_state;

    // config as the testbench expects it in the DUT
    port_mask_t model_en;
    load_t      model_cap;

    // bookkeeping
    int test_errs;
    int pass_count;
    int fail_count;

    // 4 ns period
    always #2 clk = ~clk;

    port_select_top i_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (req),
        .vc_busy (vc_busy),
        .cfg_wr  (cfg_wr),
        .resp    (resp)
    );

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // one lfsr step per bit
    task automatic take_bits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits = {bits[30:0], lfsr_state[0]};
        end
    endtask

    // random candidate mask and busy bitmaps
    task automatic random_inputs(output port_mask_t cand, output busy_arr_t busy);
        logic [31:0] bits;
        take_bits(NUM_PORTS, bits);
        cand = bits[NUM_PORTS-1:0];
        for (int p = 0; p < NUM_PORTS; p++) begin
            take_bits(NUM_VCS, bits);
            busy[p] = bits[NUM_VCS-1:0];
        end
    endtask

    function automatic int popcount(input vc_busy_t v);
        int n;
        n = 0;
        for (int i = 0; i < NUM_VCS; i++) begin
            n += v[i];
        end
        return n;
    endfunction

    // smallest load among eligible ports and lowest index on a tie
    function automatic select_resp_t model_select(input port_mask_t cand,
                                                  input busy_arr_t busy,
                                                  input port_mask_t en,
                                                  input load_t cap);
        select_resp_t r;
        load_t ld;
        r = '0;
        r.valid = 1'b1;
        for (int p = 0; p < NUM_PORTS; p++) begin
            ld = load_t'(popcount(busy[p]));
            if (cand[p] && en[p] && ld <= cap) begin
                // strict compare keeps the earlier port on a tie
                if (!r.found || ld < r.load) begin
                    r.found = 1'b1;
                    r.port = port_idx_t'(p);
                    r.load = ld;
                end
            end
        end
        return r;
    endfunction

    task automatic check_port(input string name, input port_idx_t exp, input port_idx_t act);
        if (exp !== act) begin
            $display("ERROR %s expected 0x%0h got 0x%0h at %0t", name, exp, act, $time);
            test_errs++;
        end
    endtask

    task automatic check_load(input string name, input load_t exp, input load_t act);
        if (exp !== act) begin
            $display("ERROR %s expected 0x%0h got 0x%0h at %0t", name, exp, act, $time);
            test_errs++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("ERROR %s expected 0x%0h got 0x%0h at %0t", name, exp, act, $time);
            test_errs++;
        end
    endtask

    task automatic expect_resp(input select_resp_t exp, input select_resp_t got);
        check_flag("resp.found", exp.found, got.found);
        check_port("resp.port", exp.port, got.port);
        check_load("resp.load", exp.load, got.load);
    endtask

    // called and returns on a falling edge
    task automatic run_request(input port_mask_t cand, input busy_arr_t busy,
                               input select_resp_t exp);
        int cycles;
        logic seen;
        req.strobe = 1'b1;
        req.cand = cand;
        vc_busy = busy;
        cycles = 0;
        seen = 1'b0;
        while (!seen && cycles < RESP_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            // both strobes are one cycle wide
            req.strobe = 1'b0;
            cfg_wr.we = 1'b0;
            seen = resp.valid;
        end
        if (!seen) begin
            $display("timeout: no response within %0d cycles of the strobe", RESP_TIMEOUT);
            test_errs++;
        end else begin
            if (cycles != 1) begin
                $display("response came %0d cycles after the strobe instead of 1", cycles);
                test_errs++;
            end
            expect_resp(exp, resp);
        end
    endtask

    // expected value from the model and the current config
    task automatic check_request(input port_mask_t cand, input busy_arr_t busy);
        run_request(cand, busy, model_select(cand, busy, model_en, model_cap));
    endtask

    task automatic finish_test(input string name);
        if (test_errs == 0) begin
            pass_count++;
            $display("%s: ok", name);
        end else begin
            fail_count++;
            $display("%s: %0d errors", name, test_errs);
        end
        test_errs = 0;
    endtask

    `include "tb_port_select_tests.svh"

    initial begin
        rst_n = 1'b0;
        // strobe and all candidates held during reset
        req.strobe = 1'b1;
        req.cand = '1;
        cfg_wr = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            vc_busy[p] = '0;
        end
        lfsr_state = LFSR_SEED;
        // reset values of the config block
        model_en = '1;
        model_cap = load_t'(LOAD_MAX);
        test_errs = 0;
        pass_count = 0;
        fail_count = 0;

        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        req = '0;

        reset_state();
        counter_values();
        random_traffic();
        back_to_back();
        config_changes();

        $display("tests passed %0d failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
